// ==== include/ahb_sub_params.svh ====
// bus widths, client address map, ID value and FIFO depth
`ifndef AHB_SUB_PARAMS_SVH
`define AHB_SUB_PARAMS_SVH

// bus widths
`define AHB_DW 64
`define CLI_DW 32
`define AW 32

// message FIFO entries
`define FIFO_DEPTH 8

// constant returned by the ID register
`define ID_VALUE 32'h4148_4231

// word offsets within the low five address bits
`define REG_BASE 5'h00
`define FIFO_BASE 5'h0C
`define MAP_END 5'h18 // first offset past the FIFO window

`endif

// ==== verilog/ahb_sub_pkg.sv ====
// AHB transfer and size types, client target select and register word addresses
package ahb_sub_pkg;

    // htrans encoding
    typedef enum logic [1:0] {
        HT_IDLE   = 2'b00,
        HT_BUSY   = 2'b01,
        HT_NONSEQ = 2'b10,
        HT_SEQ    = 2'b11
    } htrans_e;

    // hsize encoding, only up to dword on a 64-bit bus
    typedef enum logic [2:0] {
        SZ_BYTE  = 3'b000,
        SZ_HALF  = 3'b001,
        SZ_WORD  = 3'b010,
        SZ_DWORD = 3'b011
    } hsize_e;

    typedef enum logic [1:0] {
        TGT_REG,
        TGT_FIFO,
        TGT_NONE
    } client_tgt_e;

    // word addresses, low five bits of the client address
    typedef enum logic [4:0] {
        REG_ID        = 5'h00,
        REG_SCRATCH   = 5'h04,
        REG_CTRL      = 5'h08,
        REG_STATUS    = 5'h0C,
        REG_FIFO_DATA = 5'h10
    } reg_addr_e;

endpackage

// ==== verilog/client_if.sv ====
// client access interface between the AHB slave interface and the address decoder
`include "ahb_sub_params.svh"

interface client_if;
    import ahb_sub_pkg::*;

    logic               dv;    // one pulse per access, held through wait states
    logic               write;
    logic [`AW-1:0]     addr;
    hsize_e             size;
    logic [`CLI_DW-1:0] wdata;
    logic [`CLI_DW-1:0] rdata;
    logic               hold;  // level, stretches the data phase
    logic               error; // level, decided on the first data-phase cycle

    modport sif (
        output dv, write, addr, size, wdata,
        input  rdata, hold, error
    );

    modport cli (
        input  dv, write, addr, size, wdata,
        output rdata, hold, error
    );

endinterface

// ==== verilog/ahb_slv_sif.sv ====
// AHB-Lite slave interface with address capture, lane select and error/wait response
`include "ahb_sub_params.svh"

module ahb_slv_sif (
    input  logic                 hclk,
    input  logic                 hreset_n,
    input  logic [`AW-1:0]       haddr_i,
    input  logic [`AHB_DW-1:0]   hwdata_i,
    input  logic                 hsel_i,
    input  logic                 hwrite_i,
    input  logic                 hready_i,
    input  ahb_sub_pkg::htrans_e htrans_i,
    input  ahb_sub_pkg::hsize_e  hsize_i,
    input  logic [2:0]           hburst_i,    // no burst sequencing
    input  logic                 hmastlock_i, // no locked transfers
    input  logic [3:0]           hprot_i,     // no protection checks
    output logic                 hresp_o,
    output logic                 hreadyout_o,
    output logic [`AHB_DW-1:0]   hrdata_o,
    client_if.sif                cli
);
    import ahb_sub_pkg::*;

    localparam logic H_OKAY  = 1'b0;
    localparam logic H_ERROR = 1'b1;

    logic               error_f; // second cycle of the error response
    logic [`CLI_DW-1:0] lane;

    // control state, sampled only while the bus is ready
    always_ff @(posedge hclk or negedge hreset_n) begin
        if (!hreset_n) begin
            cli.dv    <= 1'b0;
            cli.write <= 1'b0;
            error_f   <= 1'b0;
        end else begin
            error_f <= cli.error & ~error_f; // one flagged cycle per error
            if (hready_i) begin
                cli.dv <= hsel_i & (htrans_i inside {HT_NONSEQ, HT_SEQ});
            end
            if (hready_i & hsel_i) begin
                cli.write <= hwrite_i;
            end
        end
    end

    // address phase payload
    always_ff @(posedge hclk) begin
        if (hready_i & hsel_i) begin
            cli.addr <= haddr_i;
            cli.size <= hsize_i;
        end
    end

    // write data arrives in the data phase, lane picked by address bit 2
    assign lane = cli.addr[2] ? hwdata_i[`AHB_DW-1:`CLI_DW] : hwdata_i[`CLI_DW-1:0];

    always_comb begin
        case (cli.size)
            SZ_BYTE: cli.wdata = {{(`CLI_DW-8){1'b0}}, lane[7:0]};
            SZ_HALF: cli.wdata = {{(`CLI_DW-16){1'b0}}, lane[15:0]};
            default: cli.wdata = lane;
        endcase
    end

    // read data on the half given by bit 2, other half zero
    always_comb begin
        if (cli.addr[2]) begin
            hrdata_o = {cli.rdata, {`CLI_DW{1'b0}}};
        end else begin
            hrdata_o = {{`CLI_DW{1'b0}}, cli.rdata};
        end
    end

    always_comb begin
        hreadyout_o = 1'b1;
        hresp_o     = H_OKAY;
        if (error_f) begin
            // closing error cycle, the client level is ignored here
            hresp_o = H_ERROR;
        end else if (cli.error) begin
            hreadyout_o = 1'b0;
            hresp_o     = H_ERROR;
        end else if (cli.hold) begin
            hreadyout_o = 1'b0;
        end
    end

    // two-cycle error response as AHB-Lite requires
    a_err_two_cycle: assert property (
        @(posedge hclk) disable iff (!hreset_n)
        (hresp_o == H_ERROR && !hreadyout_o) |=> (hresp_o == H_ERROR && hreadyout_o)
    );

endmodule

// ==== verilog/client_decode.sv ====
// client address decoder with unmapped-address error and read data / hold / error merge
`include "ahb_sub_params.svh"

module client_decode (
    input  logic                   hclk,
    input  logic                   hreset_n,
    client_if.cli                  cli,
    output logic                   reg_sel_o,
    output logic                   fifo_sel_o,
    output logic                   write_o,
    output ahb_sub_pkg::reg_addr_e waddr_o,
    output logic [`CLI_DW-1:0]     wdata_o,
    input  logic [`CLI_DW-1:0]     reg_rdata_i,
    input  logic                   reg_error_i,
    input  logic [`CLI_DW-1:0]     fifo_rdata_i,
    input  logic                   fifo_hold_i,
    input  logic                   fifo_error_i
);
    import ahb_sub_pkg::*;

    logic [4:0]  addr5;
    logic        word_ok; // known word and word aligned
    logic        size_ok;
    client_tgt_e tgt;

    assign addr5   = cli.addr[4:0]; // upper bits alias
    assign word_ok = addr5 inside {REG_ID, REG_SCRATCH, REG_CTRL, REG_STATUS, REG_FIFO_DATA};
    assign size_ok = (cli.size != SZ_DWORD); // no 64-bit client transfers

    always_comb begin
        tgt = TGT_NONE;
        if (word_ok && size_ok) begin
            if (addr5 inside {[`REG_BASE:`FIFO_BASE-1]}) begin
                tgt = TGT_REG;
            end else if (addr5 inside {[`FIFO_BASE:`MAP_END-1]}) begin
                tgt = TGT_FIFO;
            end
        end
    end

    assign reg_sel_o  = cli.dv && (tgt == TGT_REG);
    assign fifo_sel_o = cli.dv && (tgt == TGT_FIFO);
    assign write_o    = cli.write;
    assign waddr_o    = reg_addr_e'(addr5);
    assign wdata_o    = cli.wdata;

    always_comb begin
        cli.rdata = '0;
        if (reg_sel_o) begin
            cli.rdata = reg_rdata_i;
        end else if (fifo_sel_o) begin
            cli.rdata = fifo_rdata_i;
        end
    end

    assign cli.hold  = fifo_sel_o & fifo_hold_i;
    assign cli.error = (cli.dv && (tgt == TGT_NONE))
                     | (reg_sel_o & reg_error_i)
                     | (fifo_sel_o & fifo_error_i);

    a_one_target: assert property (
        @(posedge hclk) disable iff (!hreset_n) $onehot0({reg_sel_o, fifo_sel_o})
    );

endmodule

// ==== verilog/reg_bank.sv ====
// ID, scratch and control registers with sticky lock and read-only protection
`include "ahb_sub_params.svh"

module reg_bank (
    input  logic                   hclk,
    input  logic                   hreset_n,
    input  logic                   sel_i,
    input  logic                   write_i,
    input  ahb_sub_pkg::reg_addr_e addr_i,
    input  logic [`CLI_DW-1:0]     wdata_i,
    output logic [`CLI_DW-1:0]     rdata_o,
    output logic                   error_o
);
    import ahb_sub_pkg::*;

    logic [`CLI_DW-1:0] scratch_q;
    logic               lock_q; // ctrl bit 0
    logic               wr_en;

    // reads are combinational, errors decided in the same cycle
    always_comb begin
        rdata_o = '0;
        error_o = 1'b0;
        case (addr_i)
            REG_ID: begin
                rdata_o = `ID_VALUE;
                error_o = sel_i & write_i; // read-only
            end
            REG_SCRATCH: begin
                rdata_o = scratch_q;
                error_o = sel_i & write_i & lock_q;
            end
            REG_CTRL: begin
                rdata_o = {{(`CLI_DW-1){1'b0}}, lock_q};
            end
            default: begin
                rdata_o = '0;
            end
        endcase
    end

    // a rejected write leaves the register untouched
    assign wr_en = sel_i & write_i & ~error_o;

    always_ff @(posedge hclk or negedge hreset_n) begin
        if (!hreset_n) begin
            scratch_q <= '0;
            lock_q    <= 1'b0;
        end else if (wr_en) begin
            if (addr_i == REG_SCRATCH) begin
                scratch_q <= wdata_i; // whole word
            end
            if (addr_i == REG_CTRL) begin
                lock_q <= lock_q | wdata_i[0]; // set only, reset clears
            end
        end
    end

endmodule

// ==== verilog/msg_fifo.sv ====
// message FIFO with status word, registered read port and overflow/underflow errors
`include "ahb_sub_params.svh"

module msg_fifo (
    input  logic                   hclk,
    input  logic                   hreset_n,
    input  logic                   sel_i,
    input  logic                   write_i,
    input  ahb_sub_pkg::reg_addr_e addr_i,
    input  logic [`CLI_DW-1:0]     wdata_i,
    output logic [`CLI_DW-1:0]     rdata_o,
    output logic                   hold_o,
    output logic                   error_o
);
    import ahb_sub_pkg::*;

    localparam int PW = $clog2(`FIFO_DEPTH);
    localparam int CW = $clog2(`FIFO_DEPTH + 1);

    logic [`CLI_DW-1:0] mem [`FIFO_DEPTH];
    logic [`CLI_DW-1:0] rd_q;      // output register of the storage
    logic [PW-1:0]      wptr_q;
    logic [PW-1:0]      rptr_q;
    logic [CW-1:0]      count_q;
    logic               rd_pend_q; // pop data sits in rd_q
    logic               full;
    logic               empty;
    logic               is_stat;
    logic               push_req;
    logic               pop_req;
    logic               push;
    logic               pop;
    logic [`CLI_DW-1:0] status;

    assign full     = (count_q == CW'(`FIFO_DEPTH));
    assign empty    = (count_q == '0);
    assign is_stat  = (addr_i == REG_STATUS);
    assign push_req = sel_i & write_i & (addr_i == REG_FIFO_DATA);
    assign pop_req  = sel_i & ~write_i & (addr_i == REG_FIFO_DATA);

    // underflow errors at once, no hold
    assign hold_o  = pop_req & ~empty & ~rd_pend_q;
    assign error_o = (sel_i & write_i & is_stat) | (push_req & full) | (pop_req & empty);
    assign push    = push_req & ~full;
    assign pop     = pop_req & rd_pend_q; // pointer moves as the data returns

    assign status  = {{(`CLI_DW-10){1'b0}}, empty, full, {(8-CW){1'b0}}, count_q};
    assign rdata_o = is_stat ? status : rd_q;

    always_ff @(posedge hclk or negedge hreset_n) begin
        if (!hreset_n) begin
            wptr_q    <= '0;
            rptr_q    <= '0;
            count_q   <= '0;
            rd_pend_q <= 1'b0;
        end else begin
            rd_pend_q <= hold_o;
            if (push) begin
                wptr_q  <= wptr_q + 1'b1;
                count_q <= count_q + 1'b1;
            end else if (pop) begin
                rptr_q  <= rptr_q + 1'b1;
                count_q <= count_q - 1'b1;
            end
        end
    end

    always_ff @(posedge hclk) begin
        if (push) begin
            mem[wptr_q] <= wdata_i;
        end
        if (hold_o) begin
            rd_q <= mem[rptr_q];
        end
    end

    a_count_max: assert property (
        @(posedge hclk) disable iff (!hreset_n) count_q <= CW'(`FIFO_DEPTH)
    );

endmodule

// ==== verilog/ahb_sub_top.sv ====
// top level of the AHB-Lite peripheral, slave interface, decoder, registers and FIFO
`include "ahb_sub_params.svh"

module ahb_sub_top (
    input  logic                 hclk,
    input  logic                 hreset_n,
    input  logic [`AW-1:0]       haddr_i,
    input  logic [`AHB_DW-1:0]   hwdata_i,
    input  logic                 hsel_i,
    input  logic                 hwrite_i,
    input  logic                 hready_i,
    input  ahb_sub_pkg::htrans_e htrans_i,
    input  ahb_sub_pkg::hsize_e  hsize_i,
    input  logic [2:0]           hburst_i,
    input  logic                 hmastlock_i,
    input  logic [3:0]           hprot_i,
    output logic                 hresp_o,
    output logic                 hreadyout_o,
    output logic [`AHB_DW-1:0]   hrdata_o
);
    import ahb_sub_pkg::*;

    // decoder to target wires
    logic               reg_sel;
    logic               fifo_sel;
    logic               write;
    reg_addr_e          waddr;
    logic [`CLI_DW-1:0] wdata;
    logic [`CLI_DW-1:0] reg_rdata;
    logic               reg_error;
    logic [`CLI_DW-1:0] fifo_rdata;
    logic               fifo_hold;
    logic               fifo_error;

    client_if cli_bus ();

    ahb_slv_sif u_sif (
        .hclk        (hclk),
        .hreset_n    (hreset_n),
        .haddr_i     (haddr_i),
        .hwdata_i    (hwdata_i),
        .hsel_i      (hsel_i),
        .hwrite_i    (hwrite_i),
        .hready_i    (hready_i),
        .htrans_i    (htrans_i),
        .hsize_i     (hsize_i),
        .hburst_i    (hburst_i),
        .hmastlock_i (hmastlock_i),
        .hprot_i     (hprot_i),
        .hresp_o     (hresp_o),
        .hreadyout_o (hreadyout_o),
        .hrdata_o    (hrdata_o),
        .cli         (cli_bus.sif)
    );

    client_decode u_decode (
        .hclk         (hclk),
        .hreset_n     (hreset_n),
        .cli          (cli_bus.cli),
        .reg_sel_o    (reg_sel),
        .fifo_sel_o   (fifo_sel),
        .write_o      (write),
        .waddr_o      (waddr),
        .wdata_o      (wdata),
        .reg_rdata_i  (reg_rdata),
        .reg_error_i  (reg_error),
        .fifo_rdata_i (fifo_rdata),
        .fifo_hold_i  (fifo_hold),
        .fifo_error_i (fifo_error)
    );

    reg_bank u_regs (
        .hclk     (hclk),
        .hreset_n (hreset_n),
        .sel_i    (reg_sel),
        .write_i  (write),
        .addr_i   (waddr),
        .wdata_i  (wdata),
        .rdata_o  (reg_rdata),
        .error_o  (reg_error)
    );

    msg_fifo u_fifo (
        .hclk     (hclk),
        .hreset_n (hreset_n),
        .sel_i    (fifo_sel),
        .write_i  (write),
        .addr_i   (waddr),
        .wdata_i  (wdata),
        .rdata_o  (fifo_rdata),
        .hold_o   (fifo_hold),
        .error_o  (fifo_error)
    );

endmodule

// ==== test/tb_ahb_sub.sv ====
// testbench with stim file reader, pipelined AHB master, response checker and watchdog
`include "ahb_sub_params.svh"

module tb_ahb_sub;
    import ahb_sub_pkg::*;

    localparam int    CLK_PERIOD = 4;
    localparam string STIM_FILE  = "test/ahb_sub_stim.txt";

    logic               hclk;
    logic               hreset_n;
    logic [`AW-1:0]     haddr;
    logic [`AHB_DW-1:0] hwdata;
    logic               hsel;
    logic               hwrite;
    logic               hready;
    htrans_e            htrans;
    hsize_e             hsize;
    logic [2:0]         hburst;
    logic               hmastlock;
    logic [3:0]         hprot;
    logic               hresp;
    logic               hreadyout;
    logic [`AHB_DW-1:0] hrdata;

    // one transfer per stim line
    logic               st_write [$];
    logic [`AW-1:0]     st_addr [$];
    logic [2:0]         st_size [$];
    logic [`AHB_DW-1:0] st_wdata [$];
    logic               st_resp [$];
    logic [`AHB_DW-1:0] st_rdata [$];
    int                 n_xfer;
    bit                 loaded;
    integer             seed;

    assign hready = hreadyout; // only slave on the bus

    ahb_sub_top uut (
        .hclk        (hclk),
        .hreset_n    (hreset_n),
        .haddr_i     (haddr),
        .hwdata_i    (hwdata),
        .hsel_i      (hsel),
        .hwrite_i    (hwrite),
        .hready_i    (hready),
        .htrans_i    (htrans),
        .hsize_i     (hsize),
        .hburst_i    (hburst),
        .hmastlock_i (hmastlock),
        .hprot_i     (hprot),
        .hresp_o     (hresp),
        .hreadyout_o (hreadyout),
        .hrdata_o    (hrdata)
    );

    always #(CLK_PERIOD / 2) hclk = ~hclk;

    task automatic check_value(input logic [63:0] got, input logic [63:0] exp,
                               input string what);
        if (got !== exp) begin
            $display("** Error at time %0t: %s, got %h, expected %h", $time, what, got, exp);
            $display("** FAIL **");
            $fatal(1, "stopped at first mismatch");
        end
    endtask

    task automatic load_stim();
        int                 fd;
        int                 rc;
        int                 wr;
        int                 size;
        int                 resp;
        logic [`AW-1:0]     addr;
        logic [`AHB_DW-1:0] wdata;
        logic [`AHB_DW-1:0] rdata;
        string              line;
        fd = $fopen(STIM_FILE, "r");
        if (fd == 0) begin
            $display("cannot open the stim file %s", STIM_FILE);
            $display("** FAIL **");
            $fatal(1, "no stimulus");
        end else begin
            while ($fgets(line, fd) != 0) begin
                if (line.len() > 1 && line.getc(0) != "#") begin // skip column notes
                    rc = $sscanf(line, "%d %h %d %h %d %h", wr, addr, size, wdata, resp, rdata);
                    check_value(64'(rc), 64'd6, "field count of a stim line");
                    st_write.push_back(wr != 0);
                    st_addr.push_back(addr);
                    st_size.push_back(size[2:0]);
                    st_wdata.push_back(wdata);
                    st_resp.push_back(resp[0]);
                    st_rdata.push_back(rdata);
                end
            end
            $fclose(fd);
        end
    endtask

    // an error takes one wait cycle, so does an OKAY pop from the FIFO data port
    function automatic int waits_for(input logic wr, input logic [`AW-1:0] addr,
                                     input logic resp);
        if (resp) begin
            return 1;
        end
        if (!wr && addr[4:0] == REG_FIFO_DATA) begin
            return 1;
        end
        return 0;
    endfunction

    task automatic drive_addr(input int i);
        hsel   <= 1'b1;
        htrans <= HT_NONSEQ;
        hwrite <= st_write[i];
        haddr  <= st_addr[i];
        hsize  <= hsize_e'(st_size[i]);
    endtask

    task automatic drive_idle();
        hsel   <= 1'b0;
        htrans <= HT_IDLE;
    endtask

    task automatic finish_check(input int i, input int waits, input int err_waits,
                                input logic resp, input logic [63:0] rdat);
        string tag;
        tag = $sformatf("transfer %0d", i);
        check_value(64'(resp), 64'(st_resp[i]), {tag, " hresp"});
        check_value(64'(waits), 64'(waits_for(st_write[i], st_addr[i], st_resp[i])),
                    {tag, " wait cycles"});
        check_value(64'(err_waits), 64'(st_resp[i]), {tag, " error on the first cycle"});
        if (!st_write[i] && !st_resp[i]) begin
            check_value(rdat, st_rdata[i], {tag, " hrdata"});
        end
    endtask

    initial begin : main
        int          idx;
        int          gap;
        int          ap_idx;
        int          dp_idx;
        int          waits;
        int          err_waits;
        bit          ap_valid;
        bit          dp_valid;
        logic        rdy;
        logic        resp;
        logic [63:0] rdat;
        hclk      = 1'b0;
        hreset_n  = 1'b0;
        haddr     = '0;
        hwdata    = '0;
        hsel      = 1'b0;
        hwrite    = 1'b0;
        htrans    = HT_IDLE;
        hsize     = SZ_WORD;
        hburst    = 3'b000;
        hmastlock = 1'b0;
        hprot     = 4'b0011;
        seed      = 6;
        loaded    = 1'b0;
        load_stim();
        n_xfer = st_addr.size();
        loaded = 1'b1;
        repeat (4) @(posedge hclk);
        hreset_n <= 1'b1;
        @(negedge hclk);
        check_value(64'(hreadyout), 64'd1, "hreadyout after reset");
        check_value(64'(hresp), 64'd0, "hresp after reset");
        @(posedge hclk);
        idx       = 0;
        gap       = 0;
        ap_idx    = 0;
        dp_idx    = 0;
        waits     = 0;
        err_waits = 0;
        ap_valid  = 1'b0;
        dp_valid  = 1'b0;
        rdy       = 1'b1;
        while (idx < n_xfer || ap_valid || dp_valid) begin
            if (rdy) begin
                // accepted address phase moves into its data phase
                dp_valid  = ap_valid;
                dp_idx    = ap_idx;
                waits     = 0;
                err_waits = 0;
                if (ap_valid) begin
                    hwdata <= st_wdata[ap_idx];
                end
                if (gap > 0 || idx >= n_xfer) begin
                    gap = gap - 1;
                    drive_idle();
                    ap_valid = 1'b0;
                end else begin
                    drive_addr(idx);
                    ap_valid = 1'b1;
                    ap_idx   = idx;
                    idx      = idx + 1;
                    gap      = $unsigned($random(seed)) % 3; // 0 means pipelined
                end
            end
            @(negedge hclk);
            rdy  = hreadyout;
            resp = hresp;
            rdat = hrdata;
            if (dp_valid && !rdy) begin
                waits = waits + 1;
                if (resp) begin
                    err_waits = err_waits + 1;
                end
            end else if (dp_valid) begin
                finish_check(dp_idx, waits, err_waits, resp, rdat);
                dp_valid = 1'b0;
            end
            @(posedge hclk);
        end
        $display("** PASS **");
        $finish;
    end

    initial begin : watchdog
        wait (loaded);
        #((n_xfer * 10 + 100) * CLK_PERIOD);
        $display("timed out: the transfers did not finish in time");
        $display("** FAIL **");
        $fatal(1, "watchdog expired");
    end

endmodule

// ==== sources.f ====
+incdir+include
verilog/ahb_sub_pkg.sv
verilog/client_if.sv
verilog/ahb_slv_sif.sv
verilog/client_decode.sv
verilog/reg_bank.sv
verilog/msg_fifo.sv
verilog/ahb_sub_top.sv
test/tb_ahb_sub.sv

// ==== run_sim.sh ====
#!/bin/sh
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tb_ahb_sub -f sources.f
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

output=$(./obj_dir/Vtb_ahb_sub)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "simulation returned status $status"
    exit 1
fi

if echo "$output" | grep -qx '\*\* PASS \*\*'; then
    exit 0
fi
echo "pass message missing from simulation output"
exit 1

// ==== test/ahb_sub_stim.txt ====
# wr addr size wdata resp rdata
# wr 1=write 0=read, size 0=byte 2=word, resp 0=OKAY 1=ERROR, rdata checked on OKAY reads
0 00000000 2 0000000000000000 0 0000000041484231
0 0000000c 2 0000000000000000 0 0000020000000000
1 00000004 2 cafef00d12345678 0 0000000000000000
0 00000004 2 0000000000000000 0 cafef00d00000000
1 00000004 0 123456a599999999 0 0000000000000000
0 00000004 2 0000000000000000 0 000000a500000000
0 00000014 2 0000000000000000 1 0000000000000000
0 00000002 2 0000000000000000 1 0000000000000000
1 00000000 2 00000000ffffffff 1 0000000000000000
1 0000000c 2 ffffffff00000000 1 0000000000000000
0 00000010 2 0000000000000000 1 0000000000000000
1 00000010 2 00000000a0000001 0 0000000000000000
1 00000010 2 00000000a0000002 0 0000000000000000
1 00000010 2 00000000a0000003 0 0000000000000000
1 00000010 2 00000000a0000004 0 0000000000000000
1 00000010 2 00000000a0000005 0 0000000000000000
1 00000010 2 00000000a0000006 0 0000000000000000
1 00000010 2 00000000a0000007 0 0000000000000000
1 00000010 2 00000000a0000008 0 0000000000000000
0 0000000c 2 0000000000000000 0 0000010800000000
1 00000010 2 00000000a0000009 1 0000000000000000
0 00000010 2 0000000000000000 0 00000000a0000001
0 00000010 2 0000000000000000 0 00000000a0000002
0 0000000c 2 0000000000000000 0 0000000600000000
1 00000008 2 0000000000000001 0 0000000000000000
1 00000004 2 5555555500000000 1 0000000000000000
0 00000004 2 0000000000000000 0 000000a500000000
0 00000010 2 0000000000000000 0 00000000a0000003
0 00000010 2 0000000000000000 0 00000000a0000004
